// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_emu_glue
FLIST     ?= flist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "No pass message in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/aspect_ratio.sv ====
// Video aspect ratio from the video standard, crop setting and user mode
`timescale 1ns/10ps

module aspect_ratio
	import emu_glue_pkg::*;
(
	input  logic                clk_1x,
	input  logic                RESET,
	input  logic                is_pal,
	input  logic                fixed_blanks_off,
	input  crop_e               crop,
	input  ar_mode_e            ar_mode,
	output logic [AR_OUT_W-1:0] video_arx,
	output logic [AR_OUT_W-1:0] video_ary
);

	logic [AR_W-1:0] core_x;
	logic [AR_W-1:0] core_y;
	logic [1:0]      mode_code;

	// Core ratio, unused crop code keeps the last value
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (fixed_blanks_off) begin
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (is_pal) begin
			case (crop)
				CROP_NONE : begin core_x <= AR_PAL_NOCROP_X; core_y <= AR_PAL_NOCROP_Y; end
				CROP_8    : begin core_x <= AR_PAL_CROP8_X;  core_y <= AR_PAL_CROP8_Y;  end
				CROP_12   : begin core_x <= AR_PAL_CROP12_X; core_y <= AR_PAL_CROP12_Y; end
				default   : ;
			endcase
		end else begin
			case (crop)
				CROP_NONE : begin core_x <= AR_NTSC_NOCROP_X; core_y <= AR_NTSC_NOCROP_Y; end
				CROP_8    : begin core_x <= AR_NTSC_CROP8_X;  core_y <= AR_NTSC_CROP8_Y;  end
				CROP_12   : begin core_x <= AR_NTSC_CROP12_X; core_y <= AR_NTSC_CROP12_Y; end
				default   : ;
			endcase
		end
	end

	// Scaler preset index for the non-original modes
	assign mode_code = ar_mode - 2'd1;

	always_comb begin
		if (ar_mode == AR_ORIGINAL) begin
			video_arx = {1'b0, core_x};
			video_ary = {1'b0, core_y};
		end else begin
			video_arx = AR_OUT_W'(mode_code);
			video_ary = '0;
		end
	end

endmodule

// ==== design/dl_stream_if.sv ====
// Decoded host download stream passed from the decoder to the word packer
`timescale 1ns/10ps

interface dl_stream_if
	import emu_glue_pkg::*;
();

	// Registered mode flags
	logic                 pif_active;
	logic                 gb_active;
	logic                 pif_bank;

	// Host strobe, byte address and halfword, unregistered
	logic                 wr;
	logic [DL_ADDR_W-1:0] addr;
	logic [HALF_W-1:0]    dout;

	modport decode (
		output pif_active, gb_active, pif_bank, wr, addr, dout
	);

	modport pack (
		input pif_active, gb_active, pif_bank, wr, addr, dout
	);

endinterface

// ==== design/download_decode.sv ====
// Host download decoder that sets the mode flags and starts the cartridge copy
`timescale 1ns/10ps

module download_decode
	import emu_glue_pkg::*;
(
	input  logic                 clk_1x,
	input  logic                 RESET,
	input  logic                 ioctl_download,
	input  logic [IDX_W-1:0]     ioctl_index,
	input  logic                 ioctl_wr,
	input  logic [DL_ADDR_W-1:0] ioctl_addr,
	input  logic [HALF_W-1:0]    ioctl_dout,
	dl_stream_if.decode          stream,
	output logic                 romcopy_start,
	output logic [DL_ADDR_W-1:0] romcopy_size,
	output logic                 cart_loaded
);

	dl_kind_e dl_kind;
	logic     download_d;
	logic     main_active;
	logic     main_end;

	assign dl_kind  = dl_kind_e'(ioctl_index[5:0]);
	assign main_end = !ioctl_download && download_d && (dl_kind == DL_CART_MAIN);

	// Write port goes through untouched
	assign stream.wr   = ioctl_wr;
	assign stream.addr = ioctl_addr;
	assign stream.dout = ioctl_dout;

	// Mode flags, one cycle behind the host
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			stream.pif_active <= 1'b0;
			stream.gb_active  <= 1'b0;
			stream.pif_bank   <= 1'b0;
			main_active       <= 1'b0;
			download_d        <= 1'b0;
		end else begin
			stream.pif_active <= ioctl_download && (dl_kind == DL_PIFROM);
			stream.gb_active  <= ioctl_download && (dl_kind == DL_CART_GB);
			stream.pif_bank   <= ioctl_index[6];
			main_active       <= ioctl_download && (dl_kind == DL_CART_MAIN);
			download_d        <= ioctl_download;
		end
	end

	// Copy kick on the falling edge of a main download
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			romcopy_start <= main_end;
			if (main_active)
				cart_loaded <= 1'b1;
		end
	end

	// Final byte address is the image size
	always_ff @(posedge clk_1x) begin
		if (main_end)
			romcopy_size <= ioctl_addr;
	end

	a_copy_single : assert property (@(posedge clk_1x) disable iff (!RESET)
		romcopy_start |=> !romcopy_start);

endmodule

// ==== design/download_pack.sv ====
// Halfword packer for boot ROM words and companion cartridge RAM writes
`timescale 1ns/10ps

module download_pack
	import emu_glue_pkg::*;
(
	input  logic                  clk_1x,
	input  logic                  RESET,
	input  logic                  ram_ready,
	dl_stream_if.pack             stream,
	output logic [PIF_ADDR_W-1:0] pifrom_wraddress,
	output logic [WORD_W-1:0]     pifrom_wrdata,
	output logic                  pifrom_wren,
	output logic [DL_ADDR_W-1:0]  ram_wraddr,
	output logic [WORD_W-1:0]     ram_wrdata,
	output logic                  ram_wr,
	output logic                  ioctl_wait
);

	logic              first_half;
	logic              second_half;
	logic [HALF_W-1:0] dout_swapped;

	// Boot ROM is big endian
	function automatic logic [HALF_W-1:0] byte_swap(input logic [HALF_W-1:0] half);
		return {half[7:0], half[15:8]};
	endfunction

	assign first_half   = stream.wr && !stream.addr[1];
	assign second_half  = stream.wr && stream.addr[1];
	assign dout_swapped = byte_swap(stream.dout);

	// =========================================================================
	// Boot ROM path
	// =========================================================================
	always_ff @(posedge clk_1x) begin
		if (stream.pif_active && first_half) begin
			pifrom_wrdata[WORD_W-1:HALF_W] <= dout_swapped;
			pifrom_wraddress               <= {stream.pif_bank, stream.addr[PIF_ADDR_W:2]};
		end
		if (stream.pif_active && second_half)
			pifrom_wrdata[HALF_W-1:0] <= dout_swapped;
	end

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pifrom_wren <= 1'b0;
		end else begin
			pifrom_wren <= stream.pif_active && second_half;
		end
	end

	// =========================================================================
	// Companion cartridge path
	// =========================================================================
	always_ff @(posedge clk_1x) begin
		if (stream.gb_active && first_half) begin
			ram_wrdata[HALF_W-1:0] <= stream.dout;
			ram_wraddr             <= stream.addr + DL_ADDR_W'(CART_GB_START);
		end
		if (stream.gb_active && second_half)
			ram_wrdata[WORD_W-1:HALF_W] <= stream.dout;
	end

	// Host held off from the write until the RAM takes it
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			ram_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			ram_wr <= 1'b0;
			if (stream.gb_active) begin
				if (second_half) begin
					ram_wr     <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				if (ram_ready)
					ioctl_wait <= 1'b0;
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	a_wr_waits : assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr |-> ioctl_wait);

	a_pif_pulse : assert property (@(posedge clk_1x) disable iff (!RESET)
		pifrom_wren |=> !pifrom_wren);

endmodule

// ==== design/emu_glue_pkg.sv ====
// Shared widths, offsets, aspect ratio constants and enums of the host glue
package emu_glue_pkg;

	// =========================================================================
	// Host download
	// =========================================================================
	localparam int IDX_W         = 8;
	localparam int DL_ADDR_W     = 27;
	localparam int HALF_W        = 16;
	localparam int WORD_W        = 32;
	localparam int PIF_ADDR_W    = 10;
	// Companion cartridge image sits 8 MB into RAM
	localparam int CART_GB_START = 8388608;

	// Low six bits of the download index
	typedef enum logic [5:0] {
		DL_PIFROM    = 6'd0,
		DL_CART_MAIN = 6'd1,
		DL_CART_GB   = 6'd2
	} dl_kind_e;

	// =========================================================================
	// Video aspect ratio
	// =========================================================================
	localparam int AR_W     = 12;
	localparam int AR_OUT_W = 13;

	localparam logic [AR_W-1:0] AR_DEFAULT_X      = 12'd4;
	localparam logic [AR_W-1:0] AR_DEFAULT_Y      = 12'd3;
	localparam logic [AR_W-1:0] AR_NTSC_NOCROP_X  = 12'd512;
	localparam logic [AR_W-1:0] AR_NTSC_NOCROP_Y  = 12'd381;
	localparam logic [AR_W-1:0] AR_NTSC_CROP8_X   = 12'd1280;
	localparam logic [AR_W-1:0] AR_NTSC_CROP8_Y   = 12'd889;
	localparam logic [AR_W-1:0] AR_NTSC_CROP12_X  = 12'd2560;
	localparam logic [AR_W-1:0] AR_NTSC_CROP12_Y  = 12'd1714;
	localparam logic [AR_W-1:0] AR_PAL_NOCROP_X   = 12'd512;
	localparam logic [AR_W-1:0] AR_PAL_NOCROP_Y   = 12'd387;
	localparam logic [AR_W-1:0] AR_PAL_CROP8_X    = 12'd1024;
	localparam logic [AR_W-1:0] AR_PAL_CROP8_Y    = 12'd731;
	localparam logic [AR_W-1:0] AR_PAL_CROP12_X   = 12'd2048;
	localparam logic [AR_W-1:0] AR_PAL_CROP12_Y   = 12'd1419;

	typedef enum logic [1:0] {CROP_NONE, CROP_8, CROP_12} crop_e;

	typedef enum logic [1:0] {AR_ORIGINAL, AR_FULL, AR_CUSTOM1, AR_CUSTOM2} ar_mode_e;

	// =========================================================================
	// Pad port
	// =========================================================================
	localparam int PAD_COUNT = 4;
	localparam int USER_W    = 7;

endpackage

// ==== design/emu_glue_top.sv ====
// Host side glue of the console core with download, video ratio and pad port
`timescale 1ns/10ps

module emu_glue_top
	import emu_glue_pkg::*;
(
	input  logic                  clk_1x,
	input  logic                  RESET,
	// Host download
	input  logic                  ioctl_download,
	input  logic [IDX_W-1:0]      ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [DL_ADDR_W-1:0]  ioctl_addr,
	input  logic [HALF_W-1:0]     ioctl_dout,
	input  logic                  ram_ready,
	// Video settings
	input  logic                  is_pal,
	input  logic                  fixed_blanks_off,
	input  logic [1:0]            crop,
	input  logic [1:0]            ar_mode,
	// Pad port
	input  logic                  snac_on,
	input  logic [1:0]            pad_index,
	input  logic                  serial_out,
	input  logic [USER_W-1:0]     user_in,
	// Boot ROM
	output logic [PIF_ADDR_W-1:0] pifrom_wraddress,
	output logic [WORD_W-1:0]     pifrom_wrdata,
	output logic                  pifrom_wren,
	// Companion cartridge RAM
	output logic [DL_ADDR_W-1:0]  ram_wraddr,
	output logic [WORD_W-1:0]     ram_wrdata,
	output logic                  ram_wr,
	output logic                  ioctl_wait,
	// Main cartridge
	output logic                  romcopy_start,
	output logic [DL_ADDR_W-1:0]  romcopy_size,
	output logic                  cart_loaded,
	// Video and pad outputs
	output logic [AR_OUT_W-1:0]   video_arx,
	output logic [AR_OUT_W-1:0]   video_ary,
	output logic [USER_W-1:0]     user_out,
	output logic                  serial_in
);

	dl_stream_if dl_stream ();

	download_decode u_decode (
		.clk_1x(clk_1x), .RESET(RESET), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .stream(dl_stream.decode),
		.romcopy_start(romcopy_start), .romcopy_size(romcopy_size),
		.cart_loaded(cart_loaded)
	);

	download_pack u_pack (
		.clk_1x(clk_1x), .RESET(RESET), .ram_ready(ram_ready), .stream(dl_stream.pack),
		.pifrom_wraddress(pifrom_wraddress), .pifrom_wrdata(pifrom_wrdata),
		.pifrom_wren(pifrom_wren), .ram_wraddr(ram_wraddr), .ram_wrdata(ram_wrdata),
		.ram_wr(ram_wr), .ioctl_wait(ioctl_wait)
	);

	aspect_ratio u_aspect (
		.clk_1x(clk_1x), .RESET(RESET), .is_pal(is_pal),
		.fixed_blanks_off(fixed_blanks_off), .crop(crop_e'(crop)),
		.ar_mode(ar_mode_e'(ar_mode)), .video_arx(video_arx), .video_ary(video_ary)
	);

	pad_port_mux u_pad (
		.clk_1x(clk_1x), .RESET(RESET), .snac_on(snac_on), .pad_index(pad_index),
		.serial_out(serial_out), .user_in(user_in), .user_out(user_out),
		.serial_in(serial_in)
	);

endmodule

// ==== design/pad_port_mux.sv ====
// Serial pad line routed to one of four user port pins
`timescale 1ns/10ps

module pad_port_mux
	import emu_glue_pkg::*;
(
	input  logic                         clk_1x,
	input  logic                         RESET,
	input  logic                         snac_on,
	input  logic [$clog2(PAD_COUNT)-1:0] pad_index,
	input  logic                         serial_out,
	input  logic [USER_W-1:0]            user_in,
	output logic [USER_W-1:0]            user_out,
	output logic                         serial_in
);

	logic [$clog2(USER_W)-1:0] pin;
	logic [USER_W-1:0]         drive;

	// Pads 1..4 sit on D-, D+, RX-, RX+
	always_comb begin
		case (pad_index)
			2'd0    : pin = 3'd1;
			2'd1    : pin = 3'd0;
			2'd2    : pin = 3'd5;
			default : pin = 3'd4;
		endcase
		drive      = '1;
		drive[pin] = serial_out;
	end

	// Open drain port, idle pins stay released high
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			user_out  <= '1;
			serial_in <= 1'b1;
		end else if (snac_on) begin
			user_out  <= drive;
			serial_in <= user_in[pin];
		end else begin
			user_out  <= '1;
		end
	end

endmodule

// ==== flist.f ====
design/emu_glue_pkg.sv
design/dl_stream_if.sv
design/download_decode.sv
design/download_pack.sv
design/aspect_ratio.sv
design/pad_port_mux.sv
design/emu_glue_top.sv
test/glue_checker.sv
test/tb_emu_glue.sv

// ==== test/glue_cases.txt ====
# pif bank addr d0 d1 exp_addr exp_data | gb addr d0 d1 exp_addr exp_data hold | main last_addr
# ar pal blanks_off crop mode exp_x exp_y | pad snac idx serial user_in exp_out exp_serial_in
pif 0 000 1234 5678 000 34127856
pif 1 7f4 abcd ef01 3fd cdab01ef
gb 010 1111 2222 800010 22221111 0
gb 3ffc beef cafe 803ffc cafebeef 1
gb 100 0a0b 0c0d 800100 0c0d0a0b 0
main 1fffffe
main 400000
ar 0 0 0 0 200 17d
ar 0 0 1 0 500 379
ar 0 0 2 0 a00 6b2
ar 0 0 3 0 a00 6b2
ar 1 0 0 0 200 183
ar 1 0 1 0 400 2db
ar 1 0 2 0 800 58b
ar 1 1 2 0 004 003
ar 0 0 1 1 000 000
ar 1 0 0 2 001 000
ar 0 1 0 3 002 000
pad 1 0 0 7d 7d 0
pad 1 1 0 7f 7e 1
pad 1 2 0 5f 5f 0
pad 1 3 0 00 6f 0
pad 1 0 1 02 7f 1
pad 0 2 0 00 7f 2

// ==== test/glue_checker.sv ====
// Checker for the host glue that counts strobes, watches the protocol and compares values
`timescale 1ns/10ps

module glue_checker (
	input  logic clk_1x,
	input  logic RESET,
	input  logic pifrom_wren,
	input  logic ram_wr,
	input  logic ioctl_wait,
	input  logic romcopy_start,
	input  logic cart_loaded
);

	int   value_errors = 0;
	int   other_errors = 0;
	int   pif_pulses   = 0;
	int   ram_pulses   = 0;
	int   copy_pulses  = 0;
	logic pif_d;
	logic ram_d;
	logic copy_d;
	logic cart_d;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAIL time %0t signal %s expected %h actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic report_problem(input string msg);
		other_errors++;
		$display("Error at time %0t: %s", $time, msg);
	endtask

	function automatic int total_errors();
		return value_errors + other_errors;
	endfunction

	task automatic summary();
		$display("Errors: %0d total, %0d value mismatches, %0d other problems",
			total_errors(), value_errors, other_errors);
	endtask

	// =========================================================================
	// Strobe counting and protocol watch
	// =========================================================================
	always @(posedge clk_1x) begin
		if (!RESET) begin
			pif_d  = 1'b0;
			ram_d  = 1'b0;
			copy_d = 1'b0;
			cart_d = 1'b0;
		end else begin
			if (pifrom_wren && !pif_d)
				pif_pulses++;
			if (ram_wr && !ram_d)
				ram_pulses++;
			if (romcopy_start && !copy_d)
				copy_pulses++;
			if (pifrom_wren && pif_d)
				report_problem("pifrom_wren held high for more than one cycle");
			if (ram_wr && ram_d)
				report_problem("ram_wr held high for more than one cycle");
			if (romcopy_start && copy_d)
				report_problem("romcopy_start held high for more than one cycle");
			// Every RAM write stalls the host
			if (ram_wr && !ioctl_wait)
				report_problem("ram_wr issued without ioctl_wait raised");
			if (cart_d && !cart_loaded)
				report_problem("cart_loaded dropped before reset");
			pif_d  = pifrom_wren;
			ram_d  = ram_wr;
			copy_d = romcopy_start;
			cart_d = cart_loaded;
		end
	end

endmodule

// ==== test/tb_emu_glue.sv ====
// Testbench for the host glue, driving download, video and pad cases from a case file
`timescale 1ns/10ps

module tb_emu_glue;
	import emu_glue_pkg::*;

	localparam int MAX_CASES = 64;
	localparam int SIG_PIF   = 0;
	localparam int SIG_RAMWR = 1;
	localparam int SIG_WAIT  = 2;
	localparam int SIG_COPY  = 3;

	logic                  clk_1x;
	logic                  RESET;
	logic                  ioctl_download;
	logic [IDX_W-1:0]      ioctl_index;
	logic                  ioctl_wr;
	logic [DL_ADDR_W-1:0]  ioctl_addr;
	logic [HALF_W-1:0]     ioctl_dout;
	logic                  ram_ready;
	logic                  is_pal;
	logic                  fixed_blanks_off;
	logic [1:0]            crop;
	logic [1:0]            ar_mode;
	logic                  snac_on;
	logic [1:0]            pad_index;
	logic                  serial_out;
	logic [USER_W-1:0]     user_in;
	logic [PIF_ADDR_W-1:0] pifrom_wraddress;
	logic [WORD_W-1:0]     pifrom_wrdata;
	logic                  pifrom_wren;
	logic [DL_ADDR_W-1:0]  ram_wraddr;
	logic [WORD_W-1:0]     ram_wrdata;
	logic                  ram_wr;
	logic                  ioctl_wait;
	logic                  romcopy_start;
	logic [DL_ADDR_W-1:0]  romcopy_size;
	logic                  cart_loaded;
	logic [AR_OUT_W-1:0]   video_arx;
	logic [AR_OUT_W-1:0]   video_ary;
	logic [USER_W-1:0]     user_out;
	logic                  serial_in;

	string       kinds [MAX_CASES];
	logic [31:0] vals  [MAX_CASES][6];
	int          num_cases;
	logic        load_done;
	logic [7:0]  lfsr_state;

	emu_glue_top uut (
		.clk_1x(clk_1x), .RESET(RESET), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ram_ready(ram_ready), .is_pal(is_pal),
		.fixed_blanks_off(fixed_blanks_off), .crop(crop), .ar_mode(ar_mode),
		.snac_on(snac_on), .pad_index(pad_index), .serial_out(serial_out),
		.user_in(user_in), .pifrom_wraddress(pifrom_wraddress),
		.pifrom_wrdata(pifrom_wrdata), .pifrom_wren(pifrom_wren),
		.ram_wraddr(ram_wraddr), .ram_wrdata(ram_wrdata), .ram_wr(ram_wr),
		.ioctl_wait(ioctl_wait), .romcopy_start(romcopy_start),
		.romcopy_size(romcopy_size), .cart_loaded(cart_loaded),
		.video_arx(video_arx), .video_ary(video_ary), .user_out(user_out),
		.serial_in(serial_in)
	);

	glue_checker chk (
		.clk_1x(clk_1x), .RESET(RESET), .pifrom_wren(pifrom_wren), .ram_wr(ram_wr),
		.ioctl_wait(ioctl_wait), .romcopy_start(romcopy_start),
		.cart_loaded(cart_loaded)
	);

	initial begin
		clk_1x = 1'b0;
		forever #5 clk_1x = ~clk_1x;
	end

	// 8-bit Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic pick_delay(output int delay);
		delay = 0;
		for (int b = 0; b < 3; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			delay = (delay << 1) | int'(lfsr_state[0]);
		end
	endtask

	function automatic logic watched(input int which);
		case (which)
			SIG_PIF   : return pifrom_wren;
			SIG_RAMWR : return ram_wr;
			SIG_WAIT  : return ioctl_wait;
			default   : return romcopy_start;
		endcase
	endfunction

	// Poll on falling edges until the signal reaches the level
	task automatic wait_level(input int which, input logic level, input int limit,
			input string name);
		int n;
		n = 0;
		@(negedge clk_1x);
		while (watched(which) != level && n < limit) begin
			@(negedge clk_1x);
			n++;
		end
		if (watched(which) != level)
			chk.report_problem({name, " never reached the expected level"});
	endtask

	task automatic load_cases();
		int    fd;
		int    code;
		string kw;
		string rest;
		int    nf;
		fd = $fopen("test/glue_cases.txt", "r");
		if (fd == 0) begin
			chk.report_problem("cannot open test/glue_cases.txt");
			return;
		end
		while (!$feof(fd) && num_cases < MAX_CASES) begin
			code = $fscanf(fd, "%s", kw);
			if (code != 1)
				break;
			if (kw == "#") begin
				code = $fgets(rest, fd);
			end else begin
				nf = (kw == "main") ? 1 : 6;
				for (int k = 0; k < 6; k++)
					vals[num_cases][k] = '0;
				for (int k = 0; k < nf; k++)
					code = $fscanf(fd, "%h", vals[num_cases][k]);
				kinds[num_cases] = kw;
				num_cases++;
			end
		end
		$fclose(fd);
	endtask

	// =========================================================================
	// Case runners
	// =========================================================================
	task automatic run_pif(input int i);
		int base;
		base = chk.pif_pulses;
		@(posedge clk_1x);
		ioctl_index    <= {1'b0, vals[i][0][0], 6'd0};
		ioctl_download <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= vals[i][1][DL_ADDR_W-1:0];
		ioctl_dout <= vals[i][2][HALF_W-1:0];
		@(posedge clk_1x);
		ioctl_addr <= vals[i][1][DL_ADDR_W-1:0] + 27'd2;
		ioctl_dout <= vals[i][3][HALF_W-1:0];
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		wait_level(SIG_PIF, 1'b1, 10, "pifrom_wren");
		chk.check_value("pifrom_wraddress", vals[i][4], 32'(pifrom_wraddress));
		chk.check_value("pifrom_wrdata", vals[i][5], pifrom_wrdata);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		repeat (3) @(negedge clk_1x);
		if (chk.pif_pulses != base + 1)
			chk.report_problem("pifrom_wren did not pulse exactly once");
	endtask

	task automatic run_gb(input int i);
		int base;
		int delay;
		base = chk.ram_pulses;
		@(posedge clk_1x);
		ioctl_index    <= 8'd2;
		ioctl_download <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= vals[i][0][DL_ADDR_W-1:0];
		ioctl_dout <= vals[i][1][HALF_W-1:0];
		@(posedge clk_1x);
		ioctl_addr <= vals[i][0][DL_ADDR_W-1:0] + 27'd2;
		ioctl_dout <= vals[i][2][HALF_W-1:0];
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		wait_level(SIG_RAMWR, 1'b1, 10, "ram_wr");
		chk.check_value("ram_wraddr", vals[i][3], 32'(ram_wraddr));
		chk.check_value("ram_wrdata", vals[i][4], ram_wrdata);
		chk.check_value("ioctl_wait", 32'd1, 32'(ioctl_wait));
		if (vals[i][5][0]) begin
			// No acknowledge, the end of the download must release the host
			@(posedge clk_1x);
			ioctl_download <= 1'b0;
			wait_level(SIG_WAIT, 1'b0, 6, "ioctl_wait release at download end");
		end else begin
			pick_delay(delay);
			for (int k = 0; k <= delay; k++) begin
				@(posedge clk_1x);
				if (k == delay)
					ram_ready <= 1'b1;
				@(negedge clk_1x);
				chk.check_value("ioctl_wait", 32'd1, 32'(ioctl_wait));
			end
			@(posedge clk_1x);
			ram_ready <= 1'b0;
			@(negedge clk_1x);
			chk.check_value("ioctl_wait", 32'd0, 32'(ioctl_wait));
			@(posedge clk_1x);
			ioctl_download <= 1'b0;
		end
		repeat (3) @(negedge clk_1x);
		if (chk.ram_pulses != base + 1)
			chk.report_problem("ram_wr did not pulse exactly once per halfword pair");
	endtask

	task automatic run_main(input int i);
		int base;
		base = chk.copy_pulses;
		@(posedge clk_1x);
		ioctl_index    <= 8'd1;
		ioctl_download <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= vals[i][0][DL_ADDR_W-1:0];
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		wait_level(SIG_COPY, 1'b1, 6, "romcopy_start");
		chk.check_value("romcopy_size", vals[i][0], 32'(romcopy_size));
		repeat (3) @(negedge clk_1x);
		chk.check_value("cart_loaded", 32'd1, 32'(cart_loaded));
		if (chk.copy_pulses != base + 1)
			chk.report_problem("romcopy_start did not pulse exactly once");
	endtask

	task automatic run_ar(input int i);
		@(posedge clk_1x);
		is_pal           <= vals[i][0][0];
		fixed_blanks_off <= vals[i][1][0];
		crop             <= vals[i][2][1:0];
		ar_mode          <= vals[i][3][1:0];
		repeat (2) @(posedge clk_1x);
		@(negedge clk_1x);
		chk.check_value("video_arx", vals[i][4], 32'(video_arx));
		chk.check_value("video_ary", vals[i][5], 32'(video_ary));
	endtask

	task automatic run_pad(input int i);
		@(posedge clk_1x);
		snac_on    <= vals[i][0][0];
		pad_index  <= vals[i][1][1:0];
		serial_out <= vals[i][2][0];
		user_in    <= vals[i][3][USER_W-1:0];
		repeat (2) @(posedge clk_1x);
		@(negedge clk_1x);
		chk.check_value("user_out", vals[i][4], 32'(user_out));
		// A value of 2 marks serial_in as don't care
		if (vals[i][5] != 32'd2)
			chk.check_value("serial_in", vals[i][5], 32'(serial_in));
	endtask

	// =========================================================================
	// Main sequence
	// =========================================================================
	initial begin
		RESET            = 1'b0;
		ioctl_download   = 1'b0;
		ioctl_index      = '0;
		ioctl_wr         = 1'b0;
		ioctl_addr       = '0;
		ioctl_dout       = '0;
		ram_ready        = 1'b0;
		is_pal           = 1'b0;
		fixed_blanks_off = 1'b0;
		crop             = 2'd0;
		ar_mode          = 2'd0;
		snac_on          = 1'b0;
		pad_index        = 2'd0;
		serial_out       = 1'b1;
		user_in          = '1;
		lfsr_state       = 8'd93;
		num_cases        = 0;
		load_done        = 1'b0;
		load_cases();
		load_done = 1'b1;
		repeat (4) @(posedge clk_1x);
		RESET <= 1'b1;
		for (int i = 0; i < num_cases; i++) begin
			case (kinds[i])
				"pif"   : run_pif(i);
				"gb"    : run_gb(i);
				"main"  : run_main(i);
				"ar"    : run_ar(i);
				"pad"   : run_pad(i);
				default : chk.report_problem({"unknown case kind ", kinds[i]});
			endcase
		end
		if (num_cases == 0)
			chk.report_problem("no cases were loaded");
		chk.summary();
		if (chk.total_errors() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog sized from the number of cases
	initial begin
		wait (load_done);
		repeat (num_cases * 200 + 100) @(posedge clk_1x);
		chk.report_problem("watchdog expired before all cases finished");
		chk.summary();
		$display("TEST FAILED");
		$finish;
	end

endmodule
